// ==== busTypesPkg.sv ====
// CPU-side and chipset-side signal types, imported by the register path RTL and its testbench
package busTypesPkg;

    ////////////////////////////////////////////////////////////
    // CPU local bus
    ////////////////////////////////////////////////////////////

    // 68040 SIZ encoding
    typedef logic [1:0] sizeCode_t;

    // Low address bits A[1:0]
    typedef logic [1:0] addrLow_t;

    // Byte lanes, MSB is upper-upper, LSB is lower-lower
    typedef logic [3:0] laneMask_t;

    localparam sizeCode_t SIZ_LONG = 2'b00;
    localparam sizeCode_t SIZ_BYTE = 2'b01;
    localparam sizeCode_t SIZ_WORD = 2'b10;
    // Line is run as a long on register space
    localparam sizeCode_t SIZ_LINE = 2'b11;

    localparam laneMask_t LANE_NONE = 4'b0000;
    localparam laneMask_t LANE_ALL  = 4'b1111;

    // Request as seen at TSn
    typedef struct packed {
        logic      rnw;
        addrLow_t  addrLow;
        sizeCode_t siz;
    } cpuReq_t;

    ////////////////////////////////////////////////////////////
    // Chipset register port
    ////////////////////////////////////////////////////////////

    // 68000 style strobes, all active low
    typedef struct packed {
        logic asN;
        logic udsN;
        logic ldsN;
        logic regenN;
    } chipStrobe_t;

    // Data buffer enables and direction
    typedef struct packed {
        logic vbenN;
        logic drdenN;
        logic drdDir;
    } bufCtrl_t;

endpackage

// ==== chipBusTimingPkg.sv ====
// Register cycle states and chipset timing constants, imported by the execute and result stages
package chipBusTimingPkg;

    ////////////////////////////////////////////////////////////
    // Register cycle FSM
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        // Nothing pending
        REG_IDLE     = 2'd0,
        // Waiting for C1 rise with the bus free
        REG_WAIT_BUS = 2'd1,
        // AS, DS and REGEN low for one C1 period
        REG_STROBE   = 2'd2,
        // Strobes released, tack pulse out
        REG_DONE     = 2'd3
    } regState_t;

    ////////////////////////////////////////////////////////////
    // Timing
    ////////////////////////////////////////////////////////////

    // Flops between the chipset pins and the FSM
    localparam int DBR_SYNC_STAGES = 2;

    // TACKn low time in CLK80 cycles, one 40 MHz period
    localparam int TACK_HOLD_CYCLES = 2;

    // Hold counter width
    localparam int TACK_CNT_W = $clog2(TACK_HOLD_CYCLES + 1);

    // Remaining TACKn low cycles
    typedef logic [TACK_CNT_W-1:0] tackCnt_t;

    // Synchronizer shift register
    typedef logic [DBR_SYNC_STAGES-1:0] syncPipe_t;

endpackage

// ==== byteEnableDecode.sv ====
// Decode stage, latches a register space request at TSn and drives byte lanes and UDS/LDS
module byteEnableDecode
    import busTypesPkg::*;
(
    input  logic      CLK80,
    input  logic      RESETn,
    input  logic      TSn,
    input  logic      REGSPACEn,
    input  logic      RnW,
    input  sizeCode_t SIZ,
    input  addrLow_t  A,
    // Done pulse from the result stage
    input  logic      busy,
    output cpuReq_t   req,
    output laneMask_t lanes,
    output logic      uds,
    output logic      lds,
    output logic      start
);

    // Request in flight
    logic held;
    logic capture;

    // Lane rule for 68040 SIZ and A[1:0], big endian
    function automatic laneMask_t laneDecode(input sizeCode_t siz, input addrLow_t addr);
        laneMask_t mask;
        unique case (siz)
            SIZ_BYTE: mask = laneMask_t'(4'b1000 >> addr);
            // A1 picks the upper or lower half
            SIZ_WORD: mask = addr[1] ? 4'b0011 : 4'b1100;
            SIZ_LONG,
            SIZ_LINE: mask = LANE_ALL;
            default:  mask = LANE_ALL;
        endcase
        return mask;
    endfunction

    // Only one transfer at a time, a TSn while held is dropped
    assign capture = !TSn && !REGSPACEn && !held;

    ////////////////////////////////////////////////////////////
    // Capture and hold
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            held  <= 1'b0;
            lanes <= LANE_NONE;
            start <= 1'b0;
        end else begin
            start <= 1'b0;
            if (capture) begin
                held  <= 1'b1;
                lanes <= laneDecode(SIZ, A);
                start <= 1'b1;
            end else if (busy) begin
                // Released on the last TACKn cycle
                held  <= 1'b0;
                lanes <= LANE_NONE;
            end
        end
    end

    // Request fields only
    always_ff @(posedge CLK80) begin
        if (capture) begin
            req <= '{rnw: RnW, addrLow: A, siz: SIZ};
        end
    end

    // UDS covers the even bytes of each word, LDS the odd ones
    assign uds = lanes[3] | lanes[1];
    assign lds = lanes[2] | lanes[0];

    // A held request always owns at least one lane
    lanesHeld: assert property (@(posedge CLK80) disable iff (!RESETn)
        held |-> lanes != LANE_NONE);

endmodule

// ==== registerCycleSm.sv ====
// Execute stage, runs one 68000 style chipset register cycle on the C1/C3 phase clocks
module registerCycleSm
    import busTypesPkg::*;
    import chipBusTimingPkg::*;
(
    input  logic        CLK80,
    input  logic        RESETn,
    input  logic        C1,
    input  logic        C3,
    input  logic        DBRn,
    input  logic        start,
    input  cpuReq_t     req,
    input  logic        uds,
    input  logic        lds,
    output chipStrobe_t strobes,
    output bufCtrl_t    buffers,
    output logic        regTack
);

    // Synchronizer chains
    syncPipe_t dbrPipe;
    syncPipe_t c1Pipe;
    syncPipe_t c3Pipe;

    logic dbrSync;
    logic c1Sync;
    logic c3Sync;
    // Previous synced C1 for edge detect
    logic c1Last;
    logic c1Rise;
    // C1 rise in the expected phase
    logic busEdge;

    regState_t state;
    regState_t nextState;
    // Next cycle is a strobe cycle
    logic nextStrobe;

    ////////////////////////////////////////////////////////////
    // Chipset input synchronizers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            // Bus free, clocks low
            dbrPipe <= '1;
            c1Pipe  <= '0;
            c3Pipe  <= '0;
            c1Last  <= 1'b0;
        end else begin
            dbrPipe <= {dbrPipe[DBR_SYNC_STAGES-2:0], DBRn};
            c1Pipe  <= {c1Pipe[DBR_SYNC_STAGES-2:0], C1};
            c3Pipe  <= {c3Pipe[DBR_SYNC_STAGES-2:0], C3};
            c1Last  <= c1Sync;
        end
    end

    assign dbrSync = dbrPipe[DBR_SYNC_STAGES-1];
    assign c1Sync  = c1Pipe[DBR_SYNC_STAGES-1];
    assign c3Sync  = c3Pipe[DBR_SYNC_STAGES-1];

    assign c1Rise = c1Sync && !c1Last;

    // C3 lags C1 by a quarter period, so still low at a true C1 rise
    assign busEdge = c1Rise && !c3Sync;

    ////////////////////////////////////////////////////////////
    // Register cycle FSM
    ////////////////////////////////////////////////////////////

    always_comb begin
        nextState = state;
        unique case (state)
            REG_IDLE: begin
                if (start) begin
                    nextState = REG_WAIT_BUS;
                end
            end
            REG_WAIT_BUS: begin
                // DBRn low holds us here
                if (busEdge && dbrSync) begin
                    nextState = REG_STROBE;
                end
            end
            REG_STROBE: begin
                // One full C1 period of strobes
                if (busEdge) begin
                    nextState = REG_DONE;
                end
            end
            REG_DONE: begin
                nextState = REG_IDLE;
            end
            default: begin
                nextState = REG_IDLE;
            end
        endcase
    end

    assign nextStrobe = (nextState == REG_STROBE);

    // Outputs registered off the next state, so they line up with REG_STROBE
    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            state           <= REG_IDLE;
            strobes         <= '1;
            buffers.vbenN   <= 1'b1;
            buffers.drdenN  <= 1'b1;
            buffers.drdDir  <= 1'b0;
        end else begin
            state           <= nextState;
            strobes.asN     <= !nextStrobe;
            strobes.regenN  <= !nextStrobe;
            strobes.udsN    <= !(nextStrobe && uds);
            strobes.ldsN    <= !(nextStrobe && lds);
            buffers.vbenN   <= !nextStrobe;
            buffers.drdenN  <= !nextStrobe;
            // Buffer drives toward the chipset on writes
            buffers.drdDir  <= nextStrobe && !req.rnw;
        end
    end

    // Strobes are already high here
    assign regTack = (state == REG_DONE);

    // AS only starts with the synced bus grant high
    asNeedsBus: assert property (@(posedge CLK80) disable iff (!RESETn)
        $fell(strobes.asN) |-> $past(dbrSync));

    tackOneCycle: assert property (@(posedge CLK80) disable iff (!RESETn)
        regTack |=> !regTack);

endmodule

// ==== cycleTermination.sv ====
// Result stage, stretches the register cycle end pulse into TACKn, TBIn and TCIn
module cycleTermination
    import chipBusTimingPkg::*;
(
    input  logic CLK80,
    input  logic RESETn,
    input  logic regTack,
    output logic tackN,
    output logic tbiN,
    output logic tciN,
    output logic done
);

    // Cycles of TACKn low still to go
    tackCnt_t holdCnt;

    ////////////////////////////////////////////////////////////
    // Hold counter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            holdCnt <= '0;
        end else if (regTack) begin
            // Low from the next cycle on
            holdCnt <= tackCnt_t'(TACK_HOLD_CYCLES);
        end else if (holdCnt != '0) begin
            holdCnt <= holdCnt - 1'b1;
        end
    end

    assign tackN = (holdCnt == '0);

    // Register space is neither burstable nor cacheable
    assign tbiN = tackN;
    assign tciN = tackN;

    // Last low cycle frees the decode stage
    assign done = (holdCnt == tackCnt_t'(1));

    // Exactly the hold time, then back high
    tackWidth: assert property (@(posedge CLK80) disable iff (!RESETn)
        $fell(tackN) |-> !tackN [*TACK_HOLD_CYCLES] ##1 tackN);

endmodule

// ==== u712RegTop.sv ====
// Register access top, joins decode, execute and result stages to the local bus and chipset pins
module u712RegTop
    import busTypesPkg::*;
(
    input  logic      CLK80,
    input  logic      RESETn,
    input  logic      TSn,
    input  logic      REGSPACEn,
    input  logic      RnW,
    input  sizeCode_t SIZ,
    input  addrLow_t  A,
    input  logic      C1,
    input  logic      C3,
    input  logic      DBRn,
    output logic      ASn,
    output logic      UDSn,
    output logic      LDSn,
    output logic      REGENn,
    output logic      VBENn,
    output logic      DRDENn,
    output logic      DRDDIR,
    output logic      UUBEn,
    output logic      UMBEn,
    output logic      LMBEn,
    output logic      LLBEn,
    output logic      TACKn,
    output logic      TBIn,
    output logic      TCIn
);

    cpuReq_t     cpuReq;
    laneMask_t   laneMask;
    logic        udsReq;
    logic        ldsReq;
    logic        startPulse;
    logic        regTack;
    logic        termDone;
    chipStrobe_t strobes;
    bufCtrl_t    buffers;

    ////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////

    byteEnableDecode decode (
        .CLK80     (CLK80),
        .RESETn    (RESETn),
        .TSn       (TSn),
        .REGSPACEn (REGSPACEn),
        .RnW       (RnW),
        .SIZ       (SIZ),
        .A         (A),
        .busy      (termDone),
        .req       (cpuReq),
        .lanes     (laneMask),
        .uds       (udsReq),
        .lds       (ldsReq),
        .start     (startPulse)
    );

    // Execute
    registerCycleSm execute (
        .CLK80   (CLK80),
        .RESETn  (RESETn),
        .C1      (C1),
        .C3      (C3),
        .DBRn    (DBRn),
        .start   (startPulse),
        .req     (cpuReq),
        .uds     (udsReq),
        .lds     (ldsReq),
        .strobes (strobes),
        .buffers (buffers),
        .regTack (regTack)
    );

    // Result
    cycleTermination result (
        .CLK80   (CLK80),
        .RESETn  (RESETn),
        .regTack (regTack),
        .tackN   (TACKn),
        .tbiN    (TBIn),
        .tciN    (TCIn),
        .done    (termDone)
    );

    ////////////////////////////////////////////////////////////
    // Pin unpacking
    ////////////////////////////////////////////////////////////

    assign ASn    = strobes.asN;
    assign UDSn   = strobes.udsN;
    assign LDSn   = strobes.ldsN;
    assign REGENn = strobes.regenN;

    assign VBENn  = buffers.vbenN;
    assign DRDENn = buffers.drdenN;
    assign DRDDIR = buffers.drdDir;

    // Byte enables are active low on the pins
    assign UUBEn = ~laneMask[3];
    assign UMBEn = ~laneMask[2];
    assign LMBEn = ~laneMask[1];
    assign LLBEn = ~laneMask[0];

endmodule

// ==== tbChipBusModel.sv ====
// Testbench model of the chipset side, drives C1, C3 and random DBRn windows into the register top
module tbChipBusModel (
    input  logic CLK80,
    output logic C1,
    output logic C3,
    output logic DBRn
);
    timeunit 1ns;
    timeprecision 100ps;

    // C1 period in CLK80 cycles
    localparam int C1_PERIOD = 24;
    // C3 trails C1 by a quarter period
    localparam int C3_LAG = 6;
    // Shortest free window, longer than one C1 period plus sync delay
    localparam int DBR_HIGH_MIN = 28;

    logic [15:0] lfsr;
    // Position inside the C1 period
    int phase;
    // Cycles left in the current DBRn window
    int dbrLeft;

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit
    function automatic logic [7:0] takeBits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);
            v = {v[6:0], lfsr[0]};
        end
        return v;
    endfunction

    ////////////////////////////////////////////////////////////
    // Phase clocks and bus request
    ////////////////////////////////////////////////////////////

    initial begin
        lfsr    = 16'd75;
        phase   = 0;
        dbrLeft = DBR_HIGH_MIN;
        C1      = 1'b0;
        C3      = 1'b0;
        DBRn    = 1'b1;
        forever begin
            @(negedge CLK80);
            phase = (phase + 1) % C1_PERIOD;
            C1 = phase < C1_PERIOD / 2;
            C3 = ((phase + C1_PERIOD - C3_LAG) % C1_PERIOD) < C1_PERIOD / 2;
            if (dbrLeft > 1) begin
                dbrLeft--;
            end else if (DBRn) begin
                // Chipset grabs the bus for 1 to 16 cycles
                DBRn    = 1'b0;
                dbrLeft = 1 + takeBits(4);
            end else begin
                DBRn    = 1'b1;
                dbrLeft = DBR_HIGH_MIN + takeBits(5);
            end
        end
    end

endmodule

// ==== tbU712RegTop.sv ====
// Testbench for the register access top that checks random CPU requests against a lane rule model
module tbU712RegTop
    import busTypesPkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_REQUESTS    = 200;
    localparam int TACK_TIMEOUT    = 200;
    localparam int RELEASE_TIMEOUT = 8;
    localparam int TACK_LOW_CYCLES = 2;
    // Window in which an ignored TSn must stay silent
    localparam int QUIET_CYCLES    = 64;

    // Starts low before time 0, so no edge is seen at time 0
    logic      CLK80 = 1'b0;
    logic      RESETn;
    logic      TSn;
    logic      REGSPACEn;
    logic      RnW;
    sizeCode_t SIZ;
    addrLow_t  A;
    logic      C1;
    logic      C3;
    logic      DBRn;
    logic      ASn;
    logic      UDSn;
    logic      LDSn;
    logic      REGENn;
    logic      VBENn;
    logic      DRDENn;
    logic      DRDDIR;
    logic      UUBEn;
    logic      UMBEn;
    logic      LMBEn;
    logic      LLBEn;
    logic      TACKn;
    logic      TBIn;
    logic      TCIn;

    // Reference for the transfer in flight
    laneMask_t expLanes;
    logic      expRnw;
    logic      reqActive;

    logic [15:0] lfsr;
    int errors;
    int timeouts;
    int regRequests;
    int tackPulses;
    int asFalls;

    u712RegTop UUT (
        .CLK80(CLK80), .RESETn(RESETn), .TSn(TSn), .REGSPACEn(REGSPACEn), .RnW(RnW),
        .SIZ(SIZ), .A(A), .C1(C1), .C3(C3), .DBRn(DBRn),
        .ASn(ASn), .UDSn(UDSn), .LDSn(LDSn), .REGENn(REGENn),
        .VBENn(VBENn), .DRDENn(DRDENn), .DRDDIR(DRDDIR),
        .UUBEn(UUBEn), .UMBEn(UMBEn), .LMBEn(LMBEn), .LLBEn(LLBEn),
        .TACKn(TACKn), .TBIn(TBIn), .TCIn(TCIn)
    );

    tbChipBusModel chipBus (.CLK80(CLK80), .C1(C1), .C3(C3), .DBRn(DBRn));

    initial begin
        forever begin
            #4 CLK80 = ~CLK80;
        end
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [7:0] takeBits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);
            v = {v[6:0], lfsr[0]};
        end
        return v;
    endfunction

    // Lane 0 is upper-upper, so byte lane n sits at mask bit 3-n
    function automatic laneMask_t expectedLanes(input sizeCode_t siz, input addrLow_t a);
        laneMask_t m;
        m = LANE_NONE;
        if (siz == SIZ_BYTE) begin
            m[3 - a] = 1'b1;
        end else if (siz == SIZ_WORD) begin
            m = a[1] ? 4'b0011 : 4'b1100;
        end else begin
            m = LANE_ALL;
        end
        return m;
    endfunction

    function automatic void reportMismatch(input string msg);
        errors++;
        $display("FAILED at time %0t: %s", $time, msg);
    endfunction

    task automatic checkIdle(input string when);
        if ({ASn, UDSn, LDSn, REGENn, VBENn, DRDENn, UUBEn, UMBEn, LMBEn, LLBEn,
             TACKn, TBIn, TCIn} !== 13'h1FFF || DRDDIR !== 1'b0) begin
            reportMismatch($sformatf("outputs not idle %s", when));
        end
    endtask

    task automatic checkStrobePhase();
        logic expUds;
        logic expLds;
        expUds = expLanes[3] | expLanes[1];
        expLds = expLanes[2] | expLanes[0];
        if ({UUBEn, UMBEn, LMBEn, LLBEn} !== ~expLanes) begin
            reportMismatch($sformatf("byte enables %b, expected %b",
                {UUBEn, UMBEn, LMBEn, LLBEn}, ~expLanes));
        end
        if (UDSn !== !expUds || LDSn !== !expLds) begin
            reportMismatch($sformatf("UDSn/LDSn %b%b, expected %b%b",
                UDSn, LDSn, !expUds, !expLds));
        end
        if (REGENn !== 1'b0 || DRDENn !== 1'b0 || VBENn !== 1'b0) begin
            reportMismatch("REGENn, DRDENn or VBENn high during strobe");
        end
        if (DRDDIR !== !expRnw) begin
            reportMismatch($sformatf("DRDDIR %b with RnW %b", DRDDIR, expRnw));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Monitor sampling in the middle of the high phase
    ////////////////////////////////////////////////////////////

    initial begin
        logic       asPrev;
        logic       tackPrev;
        int         tackLen;
        logic [2:0] dbrHist;
        asPrev   = 1'b1;
        tackPrev = 1'b1;
        tackLen  = 0;
        dbrHist  = 3'b111;
        forever begin
            @(posedge CLK80);
            #2;
            if (RESETn) begin
                // DBRn as seen by the DUT at this edge and the two before
                dbrHist = {dbrHist[1:0], DBRn};
                if (ASn === 1'b0) begin
                    checkStrobePhase();
                end
                if (asPrev && ASn === 1'b0) begin
                    asFalls++;
                    if (dbrHist == 3'b000) begin
                        reportMismatch("ASn fell while DBRn was low");
                    end
                    if (!reqActive) begin
                        reportMismatch("ASn fell without a register request");
                    end
                end
                if (TBIn !== TACKn || TCIn !== TACKn) begin
                    reportMismatch("TBIn or TCIn differs from TACKn");
                end
                if (TACKn === 1'b0) begin
                    tackLen++;
                end
                if (tackPrev && TACKn === 1'b0) begin
                    if (ASn !== 1'b1) begin
                        reportMismatch("TACKn fell before ASn rose");
                    end
                    if (!reqActive) begin
                        reportMismatch("TACKn without a register request");
                    end
                end
                if (!tackPrev && TACKn === 1'b1) begin
                    tackPulses++;
                    if (tackLen != TACK_LOW_CYCLES) begin
                        reportMismatch($sformatf("TACKn low for %0d cycles", tackLen));
                    end
                    tackLen = 0;
                end
                asPrev   = ASn;
                tackPrev = TACKn;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic runRequest(input logic rnw, input sizeCode_t siz, input addrLow_t a,
                              output logic ok);
        int waitCnt;
        ok = 1'b1;
        @(negedge CLK80);
        RnW       = rnw;
        SIZ       = siz;
        A         = a;
        REGSPACEn = 1'b0;
        TSn       = 1'b0;
        expLanes  = expectedLanes(siz, a);
        expRnw    = rnw;
        reqActive = 1'b1;
        regRequests++;
        @(negedge CLK80);
        TSn = 1'b1;
        // Request held until the transfer ends
        waitCnt = 0;
        while (TACKn !== 1'b0 && waitCnt < TACK_TIMEOUT) begin
            @(negedge CLK80);
            waitCnt++;
        end
        if (TACKn !== 1'b0) begin
            $display("Timeout waiting for TACKn to fall on request %0d", regRequests);
            timeouts++;
            ok = 1'b0;
        end else begin
            REGSPACEn = 1'b1;
            waitCnt = 0;
            while (TACKn !== 1'b1 && waitCnt < RELEASE_TIMEOUT) begin
                @(negedge CLK80);
                waitCnt++;
            end
            if (TACKn !== 1'b1) begin
                $display("Timeout waiting for TACKn to rise on request %0d", regRequests);
                timeouts++;
                ok = 1'b0;
            end else begin
                reqActive = 1'b0;
                if (tackPulses != regRequests || asFalls != regRequests) begin
                    reportMismatch($sformatf("%0d TACKn and %0d ASn cycles for %0d TSn",
                        tackPulses, asFalls, regRequests));
                end
            end
        end
    endtask

    // TSn outside register space must draw no response
    task automatic sendIgnoredTs();
        @(negedge CLK80);
        REGSPACEn = 1'b1;
        TSn       = 1'b0;
        @(negedge CLK80);
        TSn = 1'b1;
        repeat (QUIET_CYCLES) @(negedge CLK80);
    endtask

    initial begin
        logic       rnw;
        sizeCode_t  siz;
        addrLow_t   a;
        logic [2:0] gap;
        logic       ok;
        int         n;
        lfsr        = 16'd75;
        errors      = 0;
        timeouts    = 0;
        regRequests = 0;
        tackPulses  = 0;
        asFalls     = 0;
        expLanes    = LANE_NONE;
        expRnw      = 1'b1;
        reqActive   = 1'b0;
        RESETn      = 1'b0;
        TSn         = 1'b1;
        REGSPACEn   = 1'b1;
        RnW         = 1'b1;
        SIZ         = SIZ_LONG;
        A           = '0;
        repeat (16) begin
            @(negedge CLK80);
            checkIdle("during reset");
        end
        RESETn = 1'b1;
        @(negedge CLK80);
        checkIdle("after reset");

        ok = 1'b1;
        n  = 0;
        while (ok && n < NUM_REQUESTS) begin
            // About one in eight requests is preceded by a non-register TSn
            if (3'(takeBits(3)) == 3'd0) begin
                sendIgnoredTs();
            end
            rnw = 1'(takeBits(1));
            siz = sizeCode_t'(takeBits(2));
            a   = addrLow_t'(takeBits(2));
            gap = 3'(takeBits(3));
            runRequest(rnw, siz, a, ok);
            repeat (gap) @(negedge CLK80);
            n++;
        end

        $display("Requests %0d, TACKn pulses %0d, errors %0d, timeouts %0d",
            regRequests, tackPulses, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
busTypesPkg.sv
chipBusTimingPkg.sv
byteEnableDecode.sv
registerCycleSm.sv
cycleTermination.sv
u712RegTop.sv
tbChipBusModel.sv
tbU712RegTop.sv
